/* Bender.yml */
package:
  name: synapse

sources:
  - src/synapse_pkg.sv
  - src/instr_sequencer.sv
  - src/register_file.sv
  - src/execute_unit.sv
  - src/synapse_core.sv
  - target: simulation
    files:
      - bench/program_rom.sv
      - bench/synapse_tb.sv

/* bench/program_rom.sv */
module program_rom import synapse_pkg::*; (
    input  logic                  sysreset,
    input  logic                  stall_en,
    input  logic [ipr_width-1:0]  code_addr,
    output logic [word_width-1:0] code_in,
    output logic                  code_ready
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int rom_words = 64;
    localparam int main_len  = 43;

    // each word is {dest, src}, imm16 data and branch targets sit inline.
    localparam logic [word_width-1:0] main_words [main_len] = '{
        // small and inline constants and neg1.
        16'h22a5, 16'h23a0, 16'h2e05, 16'h2760,
        // ad0 carry out of 0xffff + 1 and a second add that uses it.
        16'h0360, 16'h0601, 16'h2b50, 16'h2b00, 16'h2b40,
        16'h0202, 16'h2f51, 16'h2f00,
        // r0 = 0x5a3c and r1 = 0x0ff0 for the logic units and shifts.
        16'h03a0, 16'h5a3c, 16'h07a0, 16'h0ff0,
        16'h3350, 16'h3351, 16'h3352, 16'h3353,
        16'h3730, 16'h3734, 16'h3738, 16'h3700,
        // setf and clrf on the carry.
        16'hc601, 16'h3b40, 16'hc201, 16'h3b40,
        // r1 = r0 then br and bn on eq.
        16'h07a0, 16'h5a3c, 16'h3c00, 16'he345, 16'h0022,
        16'h3e01, 16'he745, 16'h0021, 16'h4340,
        // call the subroutine at 0x30 through the return swap.
        16'hfa30, 16'hfe00, 16'h4601, 16'h4c3e,
        // park in a br loop on the constant one flag.
        16'he346, 16'h0029
    };

    logic [word_width-1:0] mem [rom_words];
    logic [31:0]           rnd_state = 32'h7c61f88a;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // unused words write port 0x2f so a stray fetch shows up.
    function automatic logic [word_width-1:0] fill_word(input logic [ipr_width-1:0] addr);
        return {6'h2f, 2'b10, addr[7:0] ^ addr[15:8]};
    endfunction

    initial begin
        for (int i = 0; i < rom_words; i++) begin
            mem[i] = fill_word(ipr_width'(i));
        end
        for (int i = 0; i < main_len; i++) begin
            mem[i] = main_words[i];
        end
        // subroutine at 0x30, two port writes then return.
        mem[48] = 16'h4ac3;
        mem[49] = 16'h483e;
        mem[50] = 16'hfe00;
    end

    assign code_in = (code_addr < ipr_width'(rom_words)) ? mem[code_addr[5:0]]
                                                         : fill_word(code_addr);

    // one draw per cycle, a little after the edge.
    always @(posedge sysreset) begin
        rnd_state <= #5 xorshift32(rnd_state);
    end

    // roughly one stall cycle in four when enabled.
    assign code_ready = !stall_en || (rnd_state[1:0] != 2'b00);

endmodule

/* bench/synapse_tb.sv */
module synapse_tb import synapse_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int writes_per_run = 24;
    localparam int total_writes   = 2 * writes_per_run;
    localparam int num_tests      = 5;
    // approximate cycles of one program run without and with stalls.
    localparam int run1_cycles    = 60;
    localparam int run2_cycles    = 80;
    localparam int timeout_cycles = 2 * (run1_cycles + run2_cycles) + 200;
    localparam int settle_cycles  = 20;

    // one run's expected port writes as {addr, data}.
    localparam logic [dest_width+word_width-1:0] exp_writes [writes_per_run] = '{
        {6'h08, 16'h00a5}, {6'h08, 16'h2e05}, {6'h09, 16'hffff},
        {6'h0a, 16'h7fff}, {6'h0a, 16'h0000}, {6'h0a, 16'h0056},
        {6'h0b, 16'h0004}, {6'h0b, 16'h0004},
        {6'h0c, 16'h2d1e}, {6'h0c, 16'hb478}, {6'h0c, 16'ha3c0}, {6'h0c, 16'h05a3},
        {6'h0d, 16'h0a30}, {6'h0d, 16'h5ffc}, {6'h0d, 16'h55cc}, {6'h0d, 16'h6a2c},
        {6'h0e, 16'h0052}, {6'h0e, 16'h0050},
        {6'h0f, 16'h5a3c}, {6'h10, 16'h0060},
        {6'h12, 16'h00c3}, {6'h12, 16'h0027}, {6'h11, 16'h0001}, {6'h13, 16'h0033}
    };
    // write count at which each test is complete.
    localparam int group_end [num_tests] = '{3, 18, 20, 24, 48};

    logic                  sysreset = 1'b0;
    logic                  sysclk   = 1'b1;
    logic                  stall_en = 1'b0;
    logic [word_width-1:0] code_in;
    logic                  code_ready;
    logic [ipr_width-1:0]  code_addr;
    port_write_t           port_out;
    logic [dest_width-1:0] exp_addr;
    logic [word_width-1:0] exp_data;
    int                    cur_test;
    int                    idx = 0;
    int                    cycle_count = 0;
    int                    test_errors [num_tests];
    bit                    test_done [num_tests];
    int                    tests_passed = 0;
    int                    tests_failed = 0;
    string test_names [num_tests] = '{"constants", "alu and flags", "branches",
                                      "subroutine", "stalled rerun"};

    always #50 sysreset = ~sysreset;

    program_rom program_rom_inst (
        .sysreset   (sysreset),
        .stall_en   (stall_en),
        .code_addr  (code_addr),
        .code_in    (code_in),
        .code_ready (code_ready)
    );

    synapse_core synapse_core_inst (
        .sysreset   (sysreset),
        .sysclk     (sysclk),
        .code_in    (code_in),
        .code_ready (code_ready),
        .code_addr  (code_addr),
        .port_out   (port_out)
    );

    function automatic int test_index(input int n);
        for (int t = 0; t < num_tests; t++) begin
            if (n < group_end[t]) begin
                return t;
            end
        end
        return num_tests - 1;
    endfunction

    // second run reuses the same table.
    always_comb begin
        exp_addr = exp_writes[idx % writes_per_run][word_width +: dest_width];
        exp_data = exp_writes[idx % writes_per_run][word_width-1:0];
        cur_test = test_index(idx);
    end

    always @(posedge sysreset) begin
        if (!sysclk && port_out.strobe) begin
            idx <= idx + 1;
        end
    end

    write_addr_ok: assert property (
        @(posedge sysreset) disable iff (sysclk)
        (port_out.strobe && idx < total_writes) |-> port_out.addr == exp_addr
    ) else begin
        $display("[FAIL] port_out.addr expected %h got %h",
                 $sampled(exp_addr), $sampled(port_out.addr));
        test_errors[$sampled(cur_test)]++;
    end

    write_data_ok: assert property (
        @(posedge sysreset) disable iff (sysclk)
        (port_out.strobe && idx < total_writes) |-> port_out.data == exp_data
    ) else begin
        $display("[FAIL] port_out.data expected %h got %h",
                 $sampled(exp_data), $sampled(port_out.data));
        test_errors[$sampled(cur_test)]++;
    end

    no_extra_write: assert property (
        @(posedge sysreset) disable iff (sysclk)
        port_out.strobe |-> idx < total_writes
    ) else begin
        $display("port write to %h came after the expected sequence ended",
                 $sampled(port_out.addr));
        test_errors[num_tests-1]++;
    end

    // the first cycle out of reset fetches word 0 and writes no port.
    reset_state_ok: assert property (
        @(posedge sysreset)
        $fell(sysclk) |-> (code_addr == '0) && !port_out.strobe
    ) else begin
        $display("[FAIL] code_addr expected %h got %h, port_out.strobe expected 0 got %h",
                 {ipr_width{1'b0}}, $sampled(code_addr), $sampled(port_out.strobe));
        test_errors[$sampled(cur_test)]++;
    end

    task automatic report_test(input int t, input bit complete);
        if (!complete) begin
            test_errors[t]++;
        end
        test_done[t] = 1'b1;
        if (test_errors[t] == 0) begin
            tests_passed++;
            $display("test %0d %s: pass", t + 1, test_names[t]);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAIL with %0d errors", t + 1, test_names[t], test_errors[t]);
        end
    endtask

    // checks of an edge are done by the falling edge.
    always @(negedge sysreset) begin
        for (int t = 0; t < num_tests; t++) begin
            if (!test_done[t] && idx >= group_end[t]) begin
                report_test(t, 1'b1);
            end
        end
    end

    task automatic run_program(input bit stalls, input int max_cycles,
                               input int first_test, input int last_test);
        int waited;
        waited = 0;
        @(posedge sysreset);
        #5;
        sysclk   = 1'b1;
        stall_en = stalls;
        repeat (3) @(posedge sysreset);
        #5;
        sysclk = 1'b0;
        while (idx < group_end[last_test] && waited < max_cycles) begin
            @(posedge sysreset);
            waited++;
        end
        // the program parks in a loop so any later write is an extra one.
        repeat (settle_cycles) @(posedge sysreset);
        if (idx < group_end[last_test]) begin
            $display("only %0d of %0d port writes arrived in the run with stalls %0b",
                     idx, group_end[last_test], stalls);
        end
        for (int t = first_test; t <= last_test; t++) begin
            if (!test_done[t]) begin
                report_test(t, 1'b0);
            end
        end
    endtask

    always @(posedge sysreset) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout after %0d cycles", cycle_count);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        int total_errors;
        total_errors = 0;
        run_program(1'b0, 2 * run1_cycles, 0, 3);
        run_program(1'b1, 2 * run2_cycles, 4, 4);
        for (int t = 0; t < num_tests; t++) begin
            total_errors += test_errors[t];
        end
        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && total_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* build.f */
src/synapse_pkg.sv
src/instr_sequencer.sv
src/register_file.sv
src/execute_unit.sv
src/synapse_core.sv
bench/program_rom.sv
bench/synapse_tb.sv

/* src/execute_unit.sv */
module execute_unit import synapse_pkg::*; (
    input  logic                  sysreset,
    input  logic                  sysclk,
    input  move_t                 move,
    input  logic [word_width-1:0] regs [num_regs],
    input  operands_t             operands,
    input  logic [word_width-1:0] return_addr,
    output logic [word_width-1:0] move_value,
    output logic                  selected_flag
);

    // result registers.
    logic [word_width-1:0] ad0;
    logic [word_width-1:0] and0;
    logic [word_width-1:0] or0;
    logic [word_width-1:0] xor0;
    logic [word_width:0]   ad0_sum;
    logic [word_width-1:0] and0_comb;

    // flags.
    logic ad0_carry;
    logic ad0_zero;
    logic and0_zero;
    logic eq_flag;
    logic gt_flag;
    logic lt_flag;
    logic [word_width-1:0] flags;

    logic [word_width-1:0] sh1r;
    logic [word_width-1:0] sh1l;
    logic [word_width-1:0] sh4l;
    logic [word_width-1:0] sh4r;

    logic setf_op;
    logic clrf_op;
    logic src_mapped;

    assign setf_op = move.valid && (move.dest == op_setf);
    assign clrf_op = move.valid && (move.dest == op_clrf);

    // adder with carry in from its own carry flag.
    assign ad0_sum = {1'b0, operands.r0} + {1'b0, operands.r1}
                   + {{word_width{1'b0}}, ad0_carry};
    assign and0_comb = operands.r0 & operands.r1;

    // results load one edge after an operand write.
    always_ff @(posedge sysreset) begin
        if (operands.loaded) begin
            ad0  <= ad0_sum[word_width-1:0];
            and0 <= and0_comb;
            or0  <= operands.r0 | operands.r1;
            xor0 <= operands.r0 ^ operands.r1;
        end
    end

    always_ff @(posedge sysreset or posedge sysclk) begin
        if (sysclk) begin
            ad0_carry <= 1'b0;
            ad0_zero  <= 1'b0;
            and0_zero <= 1'b0;
        end else begin
            if (operands.loaded) begin
                ad0_zero  <= (ad0_sum[word_width-1:0] == '0);
                and0_zero <= (and0_comb == '0);
            end
            // bit 0 of the moved value is the mask for setf and clrf.
            if (setf_op) begin
                ad0_carry <= ad0_carry | move_value[0];
            end else if (clrf_op) begin
                ad0_carry <= ad0_carry & ~move_value[0];
            end else if (operands.loaded) begin
                ad0_carry <= ad0_sum[word_width];
            end
        end
    end

    // comparator runs every edge, lt lags eq and gt by one edge.
    always_ff @(posedge sysreset or posedge sysclk) begin
        if (sysclk) begin
            eq_flag <= 1'b0;
            gt_flag <= 1'b0;
            lt_flag <= 1'b0;
        end else begin
            eq_flag <= (operands.r0 == operands.r1);
            gt_flag <= (operands.r0 > operands.r1);
            lt_flag <= !(eq_flag || gt_flag);
        end
    end

    // shifts of r0, unsigned.
    assign sh1r = {1'b0, operands.r0[word_width-1:1]};
    assign sh1l = {operands.r0[word_width-2:0], 1'b0};
    assign sh4l = {operands.r0[word_width-5:0], 4'h0};
    assign sh4r = {4'h0, operands.r0[word_width-1:4]};

    always_comb begin
        flags = '0;
        flags[flag_and0_zero] = and0_zero;
        flags[flag_ad0_carry] = ad0_carry;
        flags[flag_ad0_zero]  = ad0_zero;
        flags[flag_lt]        = lt_flag;
        flags[flag_gt]        = gt_flag;
        flags[flag_eq]        = eq_flag;
        flags[flag_one]       = 1'b1;
    end

    // br and bn pick their flag by the low source bits.
    assign selected_flag = flags[move.src[flag_addr_width-1:0]];

    // source multiplexer.
    always_comb begin
        move_value = '0;
        src_mapped = 1'b1;
        if (move.src < src_width'(num_regs)) begin
            move_value = regs[move.src[reg_addr_width-1:0]];
        end else if (move.src == src_return_addr) begin
            move_value = return_addr;
        end else if (move.src[src_width-1 -: 2] == src_small_const_block[src_width-1 -: 2]) begin
            move_value = {{(word_width-8){1'b0}}, move.src[7:0]};
        end else if (move.src[src_width-1:flag_addr_width]
                     == src_flags[src_width-1:flag_addr_width]) begin
            move_value = flags;
        end else begin
            case (move.src)
                src_ad0:   move_value = ad0;
                src_and0:  move_value = and0;
                src_or0:   move_value = or0;
                src_xor0:  move_value = xor0;
                src_sh1r:  move_value = sh1r;
                src_sh1l:  move_value = sh1l;
                src_sh4l:  move_value = sh4l;
                src_sh4r:  move_value = sh4r;
                src_neg1:  move_value = '1;
                // inline constant, the sequencer skips its copy in exr.
                src_imm16: move_value = move.imm;
                default:   src_mapped = 1'b0;
            endcase
        end
    end

    // the program must only name sources that exist.
    valid_src_mapped: assert property (
        @(posedge sysreset) disable iff (sysclk)
        move.valid |-> src_mapped
    ) else $error("move from unmapped source %h", move.src);

endmodule

/* src/instr_sequencer.sv */
module instr_sequencer import synapse_pkg::*; (
    input  logic                  sysreset,
    input  logic                  sysclk,
    input  logic [word_width-1:0] code_in,
    input  logic                  code_ready,
    input  logic [word_width-1:0] move_value,
    input  logic                  selected_flag,
    output logic [ipr_width-1:0]  code_addr,
    output move_t                 move,
    output logic [word_width-1:0] return_addr
);

    // fetch pointer and the word being executed.
    logic [ipr_width-1:0]  ipr;
    logic [word_width-1:0] exr;
    logic [dest_width-1:0] exr_dest;
    logic [src_width-1:0]  exr_src;

    // exr holds no opcode while a skip flag is set.
    logic const16_cycle;
    logic branching_cycle;

    logic exec;
    logic br_op;
    logic bn_op;
    logic ret_op;
    logic wr_ret_op;
    logic imm16_op;
    logic branch_accept;

    assign exr_dest = exr[word_width-1 -: dest_width];
    assign exr_src  = exr[src_width-1:0];

    // a move runs only with the bus ready and exr holding a real opcode.
    assign exec = code_ready && !const16_cycle && !branching_cycle;

    // control destinations owned here.
    assign br_op     = exec && (exr_dest == op_br);
    assign bn_op     = exec && (exr_dest == op_bn);
    assign ret_op    = exec && (exr_dest == op_return);
    assign wr_ret_op = exec && (exr_dest == op_wr_return);
    // the data word of an inline constant is on code_in right now.
    assign imm16_op  = exec && (exr_src == src_imm16);

    // the target word is on code_in while the branch executes.
    assign branch_accept = (br_op && selected_flag) || (bn_op && !selected_flag);

    assign code_addr = ipr;

    always_comb begin
        move.valid = exec;
        move.dest  = exr_dest;
        move.src   = exr_src;
        move.imm   = code_in;
    end

    // exr follows the bus whenever a word is delivered.
    always_ff @(posedge sysreset or posedge sysclk) begin
        if (sysclk) begin
            exr <= '0;
        end else if (code_ready) begin
            exr <= code_in;
        end
    end

    // instruction pointer.
    always_ff @(posedge sysreset or posedge sysclk) begin
        if (sysclk) begin
            ipr <= '0;
        end else if (branch_accept) begin
            ipr <= code_in[ipr_width-1:0];
        end else if (ret_op) begin
            // the old ipr goes into return_addr below.
            ipr <= ipr_width'(return_addr);
        end else if (code_ready) begin
            ipr <= ipr + ipr_width'(1);
        end
    end

    // a write to 0x3e loads the return address and a return swaps it.
    always_ff @(posedge sysreset or posedge sysclk) begin
        if (sysclk) begin
            return_addr <= '0;
        end else if (ret_op) begin
            return_addr <= word_width'(ipr);
        end else if (wr_ret_op) begin
            return_addr <= move_value;
        end
    end

    // skip flags hold on through bus stalls.
    always_ff @(posedge sysreset or posedge sysclk) begin
        if (sysclk) begin
            const16_cycle   <= 1'b0;
            // exr is empty out of reset just like a branch shadow.
            branching_cycle <= 1'b1;
        end else begin
            const16_cycle   <= imm16_op || (const16_cycle && !code_ready);
            // set whether the branch is taken or not.
            // exr then holds the target word, not an opcode.
            branching_cycle <= br_op || bn_op || ret_op || (branching_cycle && !code_ready);
        end
    end

    // br and bn are never decoded together.
    br_bn_exclusive: assert property (
        @(posedge sysreset) disable iff (sysclk)
        !(br_op && bn_op)
    ) else $error("br and bn decoded together");

endmodule

/* src/register_file.sv */
module register_file import synapse_pkg::*; (
    input  logic                  sysreset,
    input  logic                  sysclk,
    input  move_t                 move,
    input  logic [word_width-1:0] move_value,
    output logic [word_width-1:0] regs [num_regs],
    output operands_t             operands,
    output port_write_t           port_out
);

    logic reg_write;
    logic port_hit;
    logic loaded;

    // r0..r7 live at the bottom of the destination space.
    assign reg_write = move.valid && (move.dest < dest_width'(num_regs));

    assign port_hit = (move.dest >= port_first) && (move.dest <= port_last);

    always_ff @(posedge sysreset or posedge sysclk) begin
        if (sysclk) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
            loaded <= 1'b0;
        end else begin
            if (reg_write) begin
                regs[move.dest[reg_addr_width-1:0]] <= move_value;
            end
            // r0 or r1 changed, the binary units load on the next edge.
            loaded <= reg_write && (move.dest[reg_addr_width-1:1] == '0);
        end
    end

    always_comb begin
        operands.r0     = regs[0];
        operands.r1     = regs[1];
        operands.loaded = loaded;
    end

    // port write is a pulse in the cycle the move executes.
    always_comb begin
        port_out.strobe = move.valid && port_hit;
        port_out.addr   = move.dest;
        port_out.data   = move_value;
    end

    port_write_in_range: assert property (
        @(posedge sysreset) disable iff (sysclk)
        port_out.strobe |-> (port_out.addr >= port_first) && (port_out.addr <= port_last)
                            && !$isunknown(port_out.data)
    ) else $error("port write outside port range or with unknown data");

endmodule

/* src/synapse_core.sv */
module synapse_core import synapse_pkg::*; (
    input  logic                  sysreset,
    input  logic                  sysclk,
    input  logic [word_width-1:0] code_in,
    input  logic                  code_ready,
    output logic [ipr_width-1:0]  code_addr,
    output port_write_t           port_out
);

    // decoded move and its selected value, shared by all three units.
    move_t                 move;
    logic [word_width-1:0] move_value;
    logic [word_width-1:0] return_addr;
    logic                  selected_flag;
    logic [word_width-1:0] regs [num_regs];
    operands_t             operands;

    // fetch, exr and branch control.
    instr_sequencer instr_sequencer_inst (
        .sysreset      (sysreset),
        .sysclk        (sysclk),
        .code_in       (code_in),
        .code_ready    (code_ready),
        .move_value    (move_value),
        .selected_flag (selected_flag),
        .code_addr     (code_addr),
        .move          (move),
        .return_addr   (return_addr)
    );

    // general registers and output port decode.
    register_file register_file_inst (
        .sysreset   (sysreset),
        .sysclk     (sysclk),
        .move       (move),
        .move_value (move_value),
        .regs       (regs),
        .operands   (operands),
        .port_out   (port_out)
    );

    // result units, flags and source select.
    execute_unit execute_unit_inst (
        .sysreset      (sysreset),
        .sysclk        (sysclk),
        .move          (move),
        .regs          (regs),
        .operands      (operands),
        .return_addr   (return_addr),
        .move_value    (move_value),
        .selected_flag (selected_flag)
    );

endmodule

/* src/synapse_pkg.sv */
package synapse_pkg;

    // data path and code address widths.
    localparam int word_width      = 16;
    localparam int ipr_width       = 16;

    // instruction word is {dest, src}.
    localparam int dest_width      = 6;
    localparam int src_width       = 10;

    // general registers r0..r7 sit at the bottom of both address spaces.
    localparam int num_regs        = 8;
    localparam int reg_addr_width  = $clog2(num_regs);

    // destinations in this range become output port writes.
    localparam logic [dest_width-1:0] port_first = 6'h08;
    localparam logic [dest_width-1:0] port_last  = 6'h2f;

    // low source bits that pick one flag for br and bn.
    localparam int flag_addr_width = 4;

    // source map.
    localparam logic [src_width-1:0] src_return_addr       = 10'h03e;
    // whole block 0x200..0x2ff, low byte is the constant.
    localparam logic [src_width-1:0] src_small_const_block = 10'h200;
    localparam logic [src_width-1:0] src_ad0               = 10'h300;
    localparam logic [src_width-1:0] src_and0              = 10'h330;
    localparam logic [src_width-1:0] src_or0               = 10'h334;
    localparam logic [src_width-1:0] src_xor0              = 10'h338;
    // flags word answers anywhere in 0x340..0x34f so br and bn can use it.
    localparam logic [src_width-1:0] src_flags             = 10'h340;
    localparam logic [src_width-1:0] src_sh1r              = 10'h350;
    localparam logic [src_width-1:0] src_sh1l              = 10'h351;
    localparam logic [src_width-1:0] src_sh4l              = 10'h352;
    localparam logic [src_width-1:0] src_sh4r              = 10'h353;
    localparam logic [src_width-1:0] src_neg1              = 10'h360;
    // value comes inline from the next code word.
    localparam logic [src_width-1:0] src_imm16             = 10'h3a0;

    // control destinations.
    typedef enum logic [dest_width-1:0] {
        op_clrf      = 6'h30,
        op_setf      = 6'h31,
        op_br        = 6'h38,
        op_bn        = 6'h39,
        op_wr_return = 6'h3e,
        op_return    = 6'h3f
    } dest_op_e;

    // bit positions inside the flags word.
    typedef enum logic [flag_addr_width-1:0] {
        flag_and0_zero = 4'd0,
        flag_ad0_carry = 4'd1,
        flag_ad0_zero  = 4'd2,
        flag_lt        = 4'd3,
        flag_gt        = 4'd4,
        flag_eq        = 4'd5,
        flag_one       = 4'd6
    } flag_sel_e;

    // one decoded move, imm is whatever code word is on the bus this cycle.
    typedef struct packed {
        logic                  valid;
        logic [dest_width-1:0] dest;
        logic [src_width-1:0]  src;
        logic [word_width-1:0] imm;
    } move_t;

    typedef struct packed {
        logic [word_width-1:0] r0;
        logic [word_width-1:0] r1;
        logic                  loaded;
    } operands_t;

    typedef struct packed {
        logic                  strobe;
        logic [dest_width-1:0] addr;
        logic [word_width-1:0] data;
    } port_write_t;

endpackage
